//--- mpu_pkg.sv
package mpu_pkg;

  // ----------------------------------------
  // Opcodes
  // ----------------------------------------
  localparam logic [3:0] OP_NOP   = 4'h0;  // No operation.
  localparam logic [3:0] OP_LOAD  = 4'h1;  // Register load from immediate.
  localparam logic [3:0] OP_ADD   = 4'h2;  // Sized field add.
  localparam logic [3:0] OP_CMP   = 4'h3;  // Equality, branch if false.
  localparam logic [3:0] OP_LT    = 4'h4;  // Less than, branch if false.
  localparam logic [3:0] OP_MASK  = 4'h5;  // Non-zero AND, branch if false.
  localparam logic [3:0] OP_JMP   = 4'h6;  // Unconditional jump.
  localparam logic [3:0] OP_MLOAD = 4'h7;  // Host memory read into register.
  localparam logic [3:0] OP_INT   = 4'h8;  // User interrupt.
  localparam logic [3:0] OP_HALT  = 4'h9;  // Stop, drop busy.

  // ----------------------------------------
  // Instruction word layout
  // ----------------------------------------
  localparam int F_OP   = 0;   // Opcode, 4 bits.
  localparam int F_SIZE = 4;   // Field size code, 2 bits.
  localparam int F_IDX  = 6;   // Four 5-bit register indices.
  localparam int F_SEL  = 26;  // Four 3-bit start bytes.
  localparam int F_IMM  = 63;  // Immediate word follows.

  typedef struct packed {
    logic [3:0]  op;     // Opcode.
    logic [1:0]  size;   // 1, 2, 4 or 8 bytes.
    logic [63:0] o0;
    logic [63:0] o1;
    logic [63:0] o2;
    logic [63:0] o3;
    logic [2:0]  s0;
    logic [2:0]  s1;
    logic [2:0]  s2;
    logic [2:0]  s3;
    logic [4:0]  idx0;   // Also write destination.
    logic [4:0]  idx1;
    logic [4:0]  idx2;
    logic [4:0]  idx3;
    logic [15:0] isize;  // Length in words.
  } mpu_op_t;

  typedef struct packed {
    logic [4:0]  idx;    // Destination register.
    logic [63:0] data;   // Source taken from byte 0.
    logic [2:0]  r_sel;  // Destination start byte.
    logic [1:0]  size;
    logic        we;
  } mpu_wr_t;

  typedef struct packed {
    logic [15:0] incr;   // Step when not loading.
    logic        load;   // Take data as next ip.
    logic [15:0] data;
  } mpu_ip_t;

  typedef struct packed {
    logic [63:0] addr;
    logic        start;  // One-cycle issue.
  } mpu_hm_req_t;

  // Byte mask for a size code, right aligned.
  function automatic logic [63:0] size_mask(input logic [1:0] size);
    case (size)
      2'd0:    return 64'h0000_0000_0000_00ff;
      2'd1:    return 64'h0000_0000_0000_ffff;
      2'd2:    return 64'h0000_0000_ffff_ffff;
      default: return 64'hffff_ffff_ffff_ffff;
    endcase
  endfunction

endpackage

//--- mpu_alu.sv
module mpu_alu (
  input  logic [1:0]  size,
  input  logic [3:0]  op,
  input  logic [63:0] o0,
  input  logic [63:0] o1,
  input  logic [63:0] o2,
  input  logic [2:0]  s0,
  input  logic [2:0]  s1,
  input  logic [2:0]  s2,
  output logic [63:0] res,
  output logic [7:0]  flags
);

  logic [63:0] m;      // Field mask.
  logic [63:0] msb;    // Top bit of the field.
  logic [63:0] a;
  logic [63:0] b;
  logic [63:0] c;
  logic [64:0] sum;
  logic        carry;

  // ----------------------------------------
  // Field extraction
  // ----------------------------------------
  assign m   = mpu_pkg::size_mask(size);
  assign msb = m ^ (m >> 1);  // Only the field's high bit.

  assign a = (o0 >> {s0, 3'b000}) & m;  // Compare left side.
  assign b = (o1 >> {s1, 3'b000}) & m;  // Add and compare right side.
  assign c = (o2 >> {s2, 3'b000}) & m;  // Second add operand.

  // ----------------------------------------
  // Operators
  // ----------------------------------------
  assign sum   = {1'b0, b} + {1'b0, c};
  assign carry = |(sum & ~{1'b0, m});  // Bit just above the field.

  always_comb begin
    unique case (op)
      mpu_pkg::OP_ADD:  res = sum[63:0] & m;  // Wraps inside the field.
      mpu_pkg::OP_CMP:  res = {63'd0, a == b};
      mpu_pkg::OP_LT:   res = {63'd0, a < b};  // Unsigned.
      mpu_pkg::OP_MASK: res = {63'd0, |(a & b)};
      default:          res = '0;
    endcase
  end

  // Sign, carry, zero.
  assign flags = {5'd0, |(res & msb), carry && (op == mpu_pkg::OP_ADD), res == '0};

endmodule

//--- mpu_execution.sv
module mpu_execution (
  input  mpu_pkg::mpu_op_t     op,
  input  logic [63:0]          hm_data,  // Latched host response.
  output mpu_pkg::mpu_ip_t     ip,
  output mpu_pkg::mpu_wr_t     wr,
  output mpu_pkg::mpu_hm_req_t hm_req,
  output logic                 user_irq,
  output logic [63:0]          user_data
);

  logic [63:0] alu_res;
  logic [7:0]  alu_flags;
  logic        is_cond;    // Branch-if-false opcode.
  logic        alu_false;

  mpu_alu alu_i (
    .size  (op.size),
    .op    (op.op),
    .o0    (op.o0),
    .o1    (op.o1),
    .o2    (op.o2),
    .s0    (op.s0),
    .s1    (op.s1),
    .s2    (op.s2),
    .res   (alu_res),
    .flags (alu_flags)
  );

  // ----------------------------------------
  // Host read and interrupt
  // ----------------------------------------
  assign hm_req.addr  = op.o1;                       // Address from idx1.
  assign hm_req.start = op.op == mpu_pkg::OP_MLOAD;  // Held while MLOAD is current.

  assign user_irq  = op.op == mpu_pkg::OP_INT;
  assign user_data = op.o0;

  // ----------------------------------------
  // Register write
  // ----------------------------------------
  assign wr.idx   = op.idx0;
  assign wr.r_sel = op.s0;
  assign wr.size  = op.size;

  always_comb begin
    unique case (op.op)
      mpu_pkg::OP_MLOAD: wr.data = hm_data;
      mpu_pkg::OP_ADD:   wr.data = alu_res;
      default:           wr.data = op.o1;  // LOAD immediate.
    endcase
  end

  assign wr.we = (op.op == mpu_pkg::OP_ADD) || (op.op == mpu_pkg::OP_LOAD) ||
                 (op.op == mpu_pkg::OP_MLOAD);

  // ----------------------------------------
  // Jumps
  // ----------------------------------------
  assign is_cond   = (op.op == mpu_pkg::OP_CMP) || (op.op == mpu_pkg::OP_LT) ||
                     (op.op == mpu_pkg::OP_MASK);
  assign alu_false = alu_flags[0];  // Zero flag marks a false result.

  always_comb begin
    unique case (op.op)
      mpu_pkg::OP_JMP:  ip.data = op.o0[15:0];
      mpu_pkg::OP_LT:   ip.data = op.o2[15:0];
      mpu_pkg::OP_CMP,
      mpu_pkg::OP_MASK: ip.data = op.o3[15:0];
      default:          ip.data = '0;
    endcase
  end

  assign ip.load = (op.op == mpu_pkg::OP_JMP) || (is_cond && alu_false);
  assign ip.incr = op.isize;  // Skips the immediate word too.

endmodule

//--- mpu_decode.sv
module mpu_decode (
  input  logic [63:0]      word0,
  input  logic [63:0]      imm,
  input  logic [63:0]      rd_data0,
  input  logic [63:0]      rd_data1,
  input  logic [63:0]      rd_data2,
  output logic [4:0]       rd_idx0,
  output logic [4:0]       rd_idx1,
  output logic [4:0]       rd_idx2,
  output mpu_pkg::mpu_op_t op
);

  logic        has_imm;
  logic [63:0] imm_v;  // Zero when no immediate word.
  logic [3:0]  opc;

  assign has_imm = word0[mpu_pkg::F_IMM];
  assign imm_v   = has_imm ? imm : '0;  // Ignore a stale second word.
  assign opc     = word0[mpu_pkg::F_OP +: 4];

  // Register read addresses.
  assign rd_idx0 = word0[mpu_pkg::F_IDX +: 5];
  assign rd_idx1 = word0[mpu_pkg::F_IDX + 5 +: 5];
  assign rd_idx2 = word0[mpu_pkg::F_IDX + 10 +: 5];

  // ----------------------------------------
  // Field unpack
  // ----------------------------------------
  always_comb begin
    op.op    = opc;
    op.size  = word0[mpu_pkg::F_SIZE +: 2];
    op.idx0  = rd_idx0;
    op.idx1  = rd_idx1;
    op.idx2  = rd_idx2;
    op.idx3  = word0[mpu_pkg::F_IDX + 15 +: 5];  // Decoded, no read port.
    op.s0    = word0[mpu_pkg::F_SEL +: 3];
    op.s1    = word0[mpu_pkg::F_SEL + 3 +: 3];
    op.s2    = word0[mpu_pkg::F_SEL + 6 +: 3];
    op.s3    = word0[mpu_pkg::F_SEL + 9 +: 3];
    op.isize = has_imm ? 16'd2 : 16'd1;

    // Operand slots, immediate replaces one per opcode.
    op.o0 = (opc == mpu_pkg::OP_JMP) ? imm_v : rd_data0;   // Jump target.
    op.o1 = (opc == mpu_pkg::OP_LOAD) ? imm_v : rd_data1;  // Load value.
    op.o2 = (opc == mpu_pkg::OP_LT) ? imm_v : rd_data2;    // LT target.
    if ((opc == mpu_pkg::OP_CMP) || (opc == mpu_pkg::OP_MASK)) begin
      op.o3 = imm_v;  // CMP and MASK target.
    end else begin
      op.o3 = '0;
    end
  end

endmodule

//--- mpu_regfile.sv
module mpu_regfile (
  input  logic             clk,
  input  logic             rst_n,
  input  mpu_pkg::mpu_wr_t wr,        // we already gated by execute.
  input  logic [4:0]       rd_idx0,
  input  logic [4:0]       rd_idx1,
  input  logic [4:0]       rd_idx2,
  output logic [63:0]      rd_data0,
  output logic [63:0]      rd_data1,
  output logic [63:0]      rd_data2
);

  logic [63:0] regs [32];
  logic [5:0]  shamt;  // Destination offset in bits.
  logic [63:0] wmask;  // Bytes to replace.
  logic [63:0] wdata;

  assign shamt = {wr.r_sel, 3'b000};
  assign wmask = mpu_pkg::size_mask(wr.size) << shamt;  // Clips past byte 7.
  assign wdata = wr.data << shamt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.we) begin
      regs[wr.idx] <= (regs[wr.idx] & ~wmask) | (wdata & wmask);  // Merge bytes.
    end
  end

  // Combinational reads.
  assign rd_data0 = regs[rd_idx0];
  assign rd_data1 = regs[rd_idx1];
  assign rd_data2 = regs[rd_idx2];

endmodule

//--- mpu_host_port.sv
module mpu_host_port #(
  parameter int HM_CREDITS = 2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mpu_pkg::mpu_hm_req_t req,        // Level while MLOAD is current.
  input  logic                 hm_rsp_valid,
  input  logic [63:0]          hm_rsp_data,
  input  logic                 hm_credit,
  output mpu_pkg::mpu_hm_req_t hm_req,
  output logic                 can_issue,
  output logic                 data_ready,
  output logic [63:0]          data
);

  localparam int CW = $clog2(HM_CREDITS + 1);

  logic [CW-1:0] credits;
  logic          pend;         // Request sent for the current MLOAD.
  logic          issue;
  logic          req_start_q;
  logic [63:0]   req_addr_q;

  assign can_issue = credits != '0;
  assign issue     = req.start && can_issue && !pend;  // One per instruction.
  assign hm_req    = '{addr: req_addr_q, start: req_start_q};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits     <= CW'(HM_CREDITS);
      pend        <= 1'b0;
      req_start_q <= 1'b0;
      data_ready  <= 1'b0;
    end else begin
      credits     <= credits - CW'(issue) + CW'(hm_credit);
      pend        <= req.start && (pend || issue);  // Drops once MLOAD retires.
      req_start_q <= issue;
      data_ready  <= hm_rsp_valid;                  // One cycle after response.
    end
  end

  always_ff @(posedge clk) begin
    if (issue) req_addr_q <= req.addr;
    if (hm_rsp_valid) data <= hm_rsp_data;  // Held for the register write.
  end

  a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
    credits <= CW'(HM_CREDITS));

endmodule

//--- mpu_sequencer.sv
module mpu_sequencer #(
  parameter int PROG_DEPTH = 256
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,
  input  logic                          prog_we,
  input  logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
  input  logic [63:0]                   prog_data,
  input  mpu_pkg::mpu_ip_t              ip_ctl,
  input  logic [3:0]                    op_code,
  input  logic                          can_issue,
  input  logic                          data_ready,
  input  logic                          irq_clear,
  output logic [63:0]                   word0,
  output logic [63:0]                   imm,
  output logic                          exec,  // Instruction retires.
  output logic                          busy
);

  localparam int AW = $clog2(PROG_DEPTH);

  typedef enum logic [2:0] {
    S_IDLE, S_FETCH, S_FETCH_IMM, S_EXEC, S_MEM, S_IRQ, S_HALT
  } state_t;

  state_t      state;
  state_t      state_nx;
  logic [63:0] prog_mem [PROG_DEPTH];
  logic [15:0] ip;
  logic [63:0] fetch_word;
  logic [AW-1:0] imm_addr;

  assign fetch_word = prog_mem[ip[AW-1:0]];
  assign imm_addr   = ip[AW-1:0] + AW'(1);  // Word after the opcode word.
  assign busy       = (state != S_IDLE) && (state != S_HALT);

  // Host program load, idle only.
  always_ff @(posedge clk) begin
    if (prog_we && !busy) prog_mem[prog_addr] <= prog_data;
  end

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_comb begin
    state_nx = state;
    exec     = 1'b0;
    unique case (state)
      S_IDLE, S_HALT: if (start) state_nx = S_FETCH;
      S_FETCH:        state_nx = fetch_word[mpu_pkg::F_IMM] ? S_FETCH_IMM : S_EXEC;
      S_FETCH_IMM:    state_nx = S_EXEC;
      S_EXEC: begin
        unique case (op_code)
          mpu_pkg::OP_MLOAD: if (can_issue) state_nx = S_MEM;  // Else hold for credit.
          mpu_pkg::OP_INT:   state_nx = S_IRQ;
          mpu_pkg::OP_HALT: begin
            exec     = 1'b1;
            state_nx = S_HALT;
          end
          default: begin
            exec     = 1'b1;
            state_nx = S_FETCH;
          end
        endcase
      end
      S_MEM: begin
        exec     = data_ready;  // Write of host data.
        state_nx = data_ready ? S_FETCH : S_MEM;
      end
      S_IRQ: begin
        exec     = irq_clear;
        state_nx = irq_clear ? S_FETCH : S_IRQ;
      end
      default: state_nx = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
      ip    <= '0;
      word0 <= '0;
    end else begin
      state <= state_nx;
      if (start && !busy) ip <= '0;  // Restart from the top.
      if (state == S_FETCH) word0 <= fetch_word;
      if (exec) begin
        ip    <= ip_ctl.load ? ip_ctl.data : ip + ip_ctl.incr;
        word0 <= '0;  // Retire to NOP, drops MLOAD and INT levels.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_FETCH_IMM) imm <= prog_mem[imm_addr];
  end

  a_stall_holds_ip: assert property (@(posedge clk) disable iff (!rst_n)
    ((state == S_MEM || state == S_IRQ) && !exec) |=> $stable(ip));

endmodule

//--- mpu_top.sv
module mpu_top #(
  parameter int PROG_DEPTH = 256,
  parameter int HM_CREDITS = 2
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          prog_we,
  input  logic [$clog2(PROG_DEPTH)-1:0] prog_addr,
  input  logic [63:0]                   prog_data,
  input  logic                          start,
  output logic                          busy,
  output mpu_pkg::mpu_hm_req_t          hm_req,
  input  logic                          hm_rsp_valid,
  input  logic [63:0]                   hm_rsp_data,
  input  logic                          hm_credit,
  output logic                          user_irq,
  output logic [63:0]                   user_data,
  input  logic                          irq_clear
);

  logic [63:0]          word0;
  logic [63:0]          imm;
  logic [63:0]          rd_data0;
  logic [63:0]          rd_data1;
  logic [63:0]          rd_data2;
  logic [4:0]           rd_idx0;
  logic [4:0]           rd_idx1;
  logic [4:0]           rd_idx2;
  logic [63:0]          hm_data;
  logic                 exec;
  logic                 can_issue;
  logic                 data_ready;
  mpu_pkg::mpu_op_t     op;
  mpu_pkg::mpu_ip_t     ip_ctl;
  mpu_pkg::mpu_wr_t     wr;
  mpu_pkg::mpu_wr_t     wr_exec;   // Write qualified by retire.
  mpu_pkg::mpu_hm_req_t exec_req;

  assign wr_exec = '{idx: wr.idx, data: wr.data, r_sel: wr.r_sel, size: wr.size,
                     we: wr.we && exec};

  mpu_sequencer #(.PROG_DEPTH(PROG_DEPTH)) sequencer_i (
    .clk, .rst_n, .start, .prog_we, .prog_addr, .prog_data,
    .ip_ctl, .op_code(op.op), .can_issue, .data_ready, .irq_clear,
    .word0, .imm, .exec, .busy
  );

  mpu_decode decode_i (
    .word0, .imm, .rd_data0, .rd_data1, .rd_data2,
    .rd_idx0, .rd_idx1, .rd_idx2, .op
  );

  mpu_execution execution_i (
    .op, .hm_data, .ip(ip_ctl), .wr, .hm_req(exec_req), .user_irq, .user_data
  );

  mpu_regfile regfile_i (
    .clk, .rst_n, .wr(wr_exec),
    .rd_idx0, .rd_idx1, .rd_idx2, .rd_data0, .rd_data1, .rd_data2
  );

  mpu_host_port #(.HM_CREDITS(HM_CREDITS)) host_port_i (
    .clk, .rst_n, .req(exec_req), .hm_rsp_valid, .hm_rsp_data, .hm_credit,
    .hm_req, .can_issue, .data_ready, .data(hm_data)
  );

endmodule

//--- tb_mpu.sv
module tb_mpu;

  localparam int PROG_DEPTH  = 256;
  localparam int HM_CREDITS  = 2;
  localparam int AW          = $clog2(PROG_DEPTH);
  localparam int N_TESTS     = 5;
  localparam int MAX_WORDS   = 64;
  localparam int MAX_IRQ     = 8;
  localparam int LIMIT       = 400 * N_TESTS;   // Cycles for the whole run.
  localparam int CREDIT_HOLD = 12;              // Host keeps credits a while.
  localparam logic [63:0] HM_PATTERN = 64'h5a5a_c3c3_0f0f_9669;
  localparam logic [63:0] TRUE_MARK  = 64'h0000_0000_0000_7a7a;
  localparam logic [63:0] FALSE_MARK = 64'h0000_0000_0000_f0f0;

  logic                 clk          = 1'b0;
  logic                 rst_n        = 1'b0;
  logic                 prog_we      = 1'b0;
  logic [AW-1:0]        prog_addr    = '0;
  logic [63:0]          prog_data    = '0;
  logic                 start        = 1'b0;
  logic                 hm_rsp_valid = 1'b0;
  logic [63:0]          hm_rsp_data  = '0;
  logic                 hm_credit    = 1'b0;
  logic                 irq_clear    = 1'b0;
  logic                 busy;
  logic                 user_irq;
  logic [63:0]          user_data;
  mpu_pkg::mpu_hm_req_t hm_req;

  // Test table.
  string       t_name   [N_TESTS];
  logic [63:0] t_prog   [N_TESTS][MAX_WORDS];
  int          t_len    [N_TESTS];
  logic [63:0] t_exp    [N_TESTS][MAX_IRQ];
  int          t_nexp   [N_TESTS];
  bit          t_starve [N_TESTS];   // Credits must run dry.
  int          cur = -1;

  int          cyc = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  logic [63:0] irq_seen [$];         // Every user_data taken.
  int          rsp_due [$];
  logic [63:0] rsp_addr [$];
  int          cred_due [$];
  int          last_rsp = 0;
  int          last_cred = 0;
  int          due;
  int          credits_seen = HM_CREDITS;  // Never below the DUT's count.
  int          starve_cnt = 0;             // Cycles with no credit left.
  int          credit_err = 0;             // Reads issued without credit.
  logic [31:0] rnd = 32'hf126;

  always #4 clk = ~clk;

  mpu_top #(.PROG_DEPTH(PROG_DEPTH), .HM_CREDITS(HM_CREDITS)) mpu_top_i (
    .clk, .rst_n, .prog_we, .prog_addr, .prog_data, .start, .busy,
    .hm_req, .hm_rsp_valid, .hm_rsp_data, .hm_credit,
    .user_irq, .user_data, .irq_clear
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // One instruction word in the ISA field layout.
  function automatic logic [63:0] encode(input logic [3:0] op, input logic [1:0] size,
      input logic [4:0] r0, input logic [4:0] r1, input logic [4:0] r2,
      input logic [2:0] s0, input logic [2:0] s1, input logic has_imm);
    logic [63:0] w;
    w        = '0;
    w[3:0]   = op;
    w[5:4]   = size;
    w[10:6]  = r0;
    w[15:11] = r1;
    w[20:16] = r2;
    w[28:26] = s0;
    w[31:29] = s1;
    w[63]    = has_imm;  // Second word follows.
    return w;
  endfunction

  // ----------------------------------------
  // Table building
  // ----------------------------------------
  task automatic new_test(input string name, input bit starve);
    cur++;
    t_name[cur]   = name;
    t_len[cur]    = 0;
    t_nexp[cur]   = 0;
    t_starve[cur] = starve;
  endtask

  task automatic emit(input logic [63:0] w);
    t_prog[cur][t_len[cur]] = w;
    t_len[cur]++;
  endtask

  task automatic expect_irq(input logic [63:0] v);
    t_exp[cur][t_nexp[cur]] = v;
    t_nexp[cur]++;
  endtask

  task automatic emit_load(input logic [4:0] r, input logic [1:0] size,
                           input logic [2:0] sel, input logic [63:0] v);
    emit(encode(mpu_pkg::OP_LOAD, size, r, 5'd0, 5'd0, sel, 3'd0, 1'b1));
    emit(v);
  endtask

  task automatic emit_op(input logic [3:0] op, input logic [4:0] r);
    emit(encode(op, 2'd0, r, 5'd0, 5'd0, 3'd0, 3'd0, 1'b0));
  endtask

  // Condition with one INT on the true path and one on the false path.
  task automatic emit_branch(input logic [3:0] op, input logic [4:0] ra, input logic [2:0] sa,
                             input logic [4:0] rb, input logic [2:0] sb, input bit is_true);
    int p;
    p = t_len[cur];
    emit(encode(op, 2'd0, ra, rb, 5'd0, sa, sb, 1'b1));
    emit(64'(p + 5));                   // False target.
    emit_op(mpu_pkg::OP_INT, 5'd10);
    emit(encode(mpu_pkg::OP_JMP, 2'd0, 5'd0, 5'd0, 5'd0, 3'd0, 3'd0, 1'b1));
    emit(64'(p + 6));                   // Past the false marker.
    emit_op(mpu_pkg::OP_INT, 5'd11);
    expect_irq(is_true ? TRUE_MARK : FALSE_MARK);
  endtask

  task automatic build_table();
    new_test("load_int", 1'b0);
    emit_load(5'd1, 2'd3, 3'd0, 64'h1122_3344_5566_7788);
    emit_op(mpu_pkg::OP_INT, 5'd1);
    emit_load(5'd1, 2'd2, 3'd2, 64'h0000_0000_aabb_ccdd);  // Bytes 2..5.
    emit_op(mpu_pkg::OP_INT, 5'd1);
    emit_load(5'd1, 2'd2, 3'd6, 64'h0000_0000_eeff_0102);  // Clipped at byte 7.
    emit_op(mpu_pkg::OP_INT, 5'd1);
    emit_op(mpu_pkg::OP_HALT, 5'd0);
    expect_irq(64'h1122_3344_5566_7788);
    expect_irq(64'h1122_aabb_ccdd_7788);
    expect_irq(64'h0102_aabb_ccdd_7788);

    new_test("add_sizes", 1'b0);
    emit_load(5'd2, 2'd3, 3'd0, 64'h0000_0000_0000_00f0);
    emit_load(5'd3, 2'd3, 3'd0, 64'h0000_0000_0000_0025);
    emit_load(5'd4, 2'd3, 3'd0, 64'haaaa_aaaa_aaaa_aaaa);
    emit(encode(mpu_pkg::OP_ADD, 2'd0, 5'd4, 5'd2, 5'd3, 3'd3, 3'd0, 1'b0));
    emit_op(mpu_pkg::OP_INT, 5'd4);
    emit_load(5'd5, 2'd3, 3'd0, 64'h1234_5678_ffff_ffff);
    emit_load(5'd6, 2'd3, 3'd0, 64'h0000_0001_0000_0001);
    emit(encode(mpu_pkg::OP_ADD, 2'd3, 5'd7, 5'd5, 5'd6, 3'd0, 3'd0, 1'b0));
    emit_op(mpu_pkg::OP_INT, 5'd7);
    emit_op(mpu_pkg::OP_HALT, 5'd0);
    expect_irq(64'haaaa_aaaa_15aa_aaaa);  // 0xf0 + 0x25 wraps to 0x15 at byte 3.
    expect_irq(64'h1234_567a_0000_0000);

    new_test("branches", 1'b0);
    emit_load(5'd1, 2'd3, 3'd0, 64'd5);
    emit_load(5'd3, 2'd3, 3'd0, 64'd9);
    emit_load(5'd4, 2'd3, 3'd0, 64'h0f0);
    emit_load(5'd5, 2'd3, 3'd0, 64'h00f);
    emit_load(5'd6, 2'd3, 3'd0, 64'h500);  // Five in byte 1.
    emit_load(5'd10, 2'd3, 3'd0, TRUE_MARK);
    emit_load(5'd11, 2'd3, 3'd0, FALSE_MARK);
    emit_branch(mpu_pkg::OP_CMP, 5'd6, 3'd1, 5'd1, 3'd0, 1'b1);
    emit_branch(mpu_pkg::OP_CMP, 5'd1, 3'd0, 5'd3, 3'd0, 1'b0);
    emit_branch(mpu_pkg::OP_LT, 5'd1, 3'd0, 5'd3, 3'd0, 1'b1);
    emit_branch(mpu_pkg::OP_LT, 5'd3, 3'd0, 5'd1, 3'd0, 1'b0);
    emit_branch(mpu_pkg::OP_MASK, 5'd5, 3'd0, 5'd3, 3'd0, 1'b1);
    emit_branch(mpu_pkg::OP_MASK, 5'd4, 3'd0, 5'd5, 3'd0, 1'b0);
    emit_op(mpu_pkg::OP_HALT, 5'd0);

    new_test("jmp_skip", 1'b0);
    emit_load(5'd12, 2'd3, 3'd0, 64'hc0de_0001);
    emit_load(5'd13, 2'd3, 3'd0, 64'hc0de_0002);
    emit(encode(mpu_pkg::OP_JMP, 2'd0, 5'd0, 5'd0, 5'd0, 3'd0, 3'd0, 1'b1));
    emit(64'd7);
    emit_op(mpu_pkg::OP_INT, 5'd12);      // Skipped.
    emit_op(mpu_pkg::OP_INT, 5'd13);
    emit(encode(mpu_pkg::OP_JMP, 2'd0, 5'd0, 5'd0, 5'd0, 3'd0, 3'd0, 1'b1));
    emit(64'd11);
    emit_op(mpu_pkg::OP_INT, 5'd12);      // Skipped.
    emit_op(mpu_pkg::OP_HALT, 5'd0);
    expect_irq(64'hc0de_0002);

    new_test("mload_credits", 1'b1);
    for (int k = 0; k < 4; k++) begin
      emit_load(5'(14 + k), 2'd3, 3'd0, 64'h1000 * (k + 1) + 64'(8 * k));
    end
    for (int k = 0; k < 4; k++) begin
      emit(encode(mpu_pkg::OP_MLOAD, 2'd3, 5'(20 + k), 5'(14 + k), 5'd0, 3'd0, 3'd0, 1'b0));
    end
    for (int k = 0; k < 4; k++) begin
      emit_op(mpu_pkg::OP_INT, 5'(20 + k));
      expect_irq((64'h1000 * (k + 1) + 64'(8 * k)) ^ HM_PATTERN);
    end
    emit_op(mpu_pkg::OP_HALT, 5'd0);
  endtask

  // ----------------------------------------
  // Host memory model and interrupt handler
  // ----------------------------------------
  always @(posedge clk) begin
    hm_rsp_valid <= 1'b0;
    hm_credit    <= 1'b0;
    if (rst_n) begin
      if (hm_req.start) begin
        assert (credits_seen > 0) else begin
          $display("error: host read issued at cycle %0d with no credit left", cyc);
          credit_err++;
        end
        rnd = lcg_step(rnd);
        due = cyc + 1 + int'(rnd[17:16]);  // 1 to 4 cycles.
        if (due <= last_rsp) due = last_rsp + 1;  // Keep request order.
        last_rsp = due;
        rsp_due.push_back(due);
        rsp_addr.push_back(hm_req.addr);
        credits_seen--;
      end
      if (rsp_due.size() > 0 && rsp_due[0] <= cyc) begin
        hm_rsp_valid <= 1'b1;
        hm_rsp_data  <= rsp_addr.pop_front() ^ HM_PATTERN;
        void'(rsp_due.pop_front());
        rnd = lcg_step(rnd);
        due = cyc + CREDIT_HOLD + 1 + int'(rnd[17:16]);
        if (due <= last_cred) due = last_cred + 1;
        last_cred = due;
        cred_due.push_back(due);
      end
      if (cred_due.size() > 0 && cred_due[0] <= cyc) begin
        hm_credit <= 1'b1;
        void'(cred_due.pop_front());
        credits_seen++;
      end
      if (credits_seen == 0) starve_cnt++;
    end
  end

  always @(posedge clk) begin
    irq_clear <= 1'b0;
    if (rst_n && user_irq && !irq_clear) begin  // Level still high while clearing.
      irq_seen.push_back(user_data);
      irq_clear <= 1'b1;
    end
  end

  // Run limit.
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT) begin
      $display("timeout: the DUT did not finish within %0d cycles", LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  task automatic load_program(input int i);
    for (int k = 0; k < t_len[i]; k++) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= AW'(k);
      prog_data <= t_prog[i][k];
    end
    @(posedge clk);
    prog_we <= 1'b0;
  endtask

  task automatic run_program(input int i, input int run);
    int base;
    int starve_base;
    int err_base;
    int n;
    int bad;
    base        = irq_seen.size();
    starve_base = starve_cnt;
    err_base    = credit_err;
    bad         = 0;
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(posedge clk);
    while (busy) @(posedge clk);   // HALT drops busy.
    n = irq_seen.size() - base;
    assert (n == t_nexp[i]) else begin
      $display("error: %s run %0d irq count expected %0d actual %0d",
               t_name[i], run, t_nexp[i], n);
      bad++;
    end
    for (int k = 0; k < n && k < t_nexp[i]; k++) begin
      assert (irq_seen[base + k] == t_exp[i][k]) else begin
        $display("error: %s run %0d irq %0d expected %h actual %h",
                 t_name[i], run, k, t_exp[i][k], irq_seen[base + k]);
        bad++;
      end
    end
    assert (!t_starve[i] || starve_cnt != starve_base) else begin
      $display("error: %s run %0d never ran out of host credits", t_name[i], run);
      bad++;
    end
    assert (credit_err == err_base) else begin
      $display("error: %s run %0d issued a host read without a credit", t_name[i], run);
      bad++;
    end
    if (bad == 0) n_pass++;
    else n_fail++;
    $display("%s run %0d: %s", t_name[i], run, (bad == 0) ? "ok" : "wrong");
  endtask

  initial begin
    build_table();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < N_TESTS; i++) begin
      load_program(i);
      for (int run = 0; run < 2; run++) begin  // Second start reruns it.
        run_program(i, run);
      end
    end
    $display("%0d runs, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
mpu_pkg.sv
mpu_alu.sv
mpu_execution.sv
mpu_decode.sv
mpu_regfile.sv
mpu_host_port.sv
mpu_sequencer.sv
mpu_top.sv
tb_mpu.sv
